/* dma_pkg.sv */
`default_nettype none

package dma_pkg;

  ////////////////////////////////////////////////////////////
  // basic words
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;

  // configuration word, tag travels next to the data
  typedef struct packed {
    logic  tag;
    word_t data;
  } tword_t;

  ////////////////////////////////////////////////////////////
  // capability layout
  ////////////////////////////////////////////////////////////

  // upper half of a capability, bits 65:33 of cap_t
  typedef struct packed {
    logic       tag;
    logic [3:0] rsvd;
    logic [3:0] perms;
    logic [1:0] spare;
    logic [3:0] exp;
    logic [8:0] base;
    logic [8:0] top;
  } cap_hi_t;

  // low half is the tagged address, its tag alone decides validity
  typedef struct packed {
    cap_hi_t hi;
    tword_t  lo;
  } cap_t;

  // permission bits inside cap_hi_t.perms
  localparam int unsigned PERM_GL = 0;
  localparam int unsigned PERM_LD = 1;
  localparam int unsigned PERM_SD = 2;
  localparam int unsigned PERM_SE = 3;

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////

  localparam int unsigned IDX_W = 6;
  typedef logic [IDX_W-1:0] reg_idx_t;

  localparam reg_idx_t REG_SRC_LO  = 6'd0;
  localparam reg_idx_t REG_SRC_HI  = 6'd1;
  localparam reg_idx_t REG_DST_LO  = 6'd2;
  localparam reg_idx_t REG_DST_HI  = 6'd3;
  localparam reg_idx_t REG_LEN     = 6'd4;
  localparam reg_idx_t REG_SSTRIDE = 6'd5;
  localparam reg_idx_t REG_TSTRIDE = 6'd6;
  localparam reg_idx_t REG_CTRL    = 6'd7;
  localparam reg_idx_t REG_STATUS  = 6'd8;

  // control and status bit positions
  localparam int unsigned CTRL_START   = 0;
  localparam int unsigned CTRL_SWAP16  = 1;
  localparam int unsigned CTRL_SWAP32  = 2;
  localparam int unsigned CTRL_RESTART = 3;
  localparam int unsigned STAT_BUSY    = 0;
  localparam int unsigned STAT_DONE    = 1;

  // one map bit per 8-byte granule, 32 bits per map word
  localparam int unsigned GRANULE_SHIFT = 3;
  localparam int unsigned MAP_BIT_W     = 5;

  ////////////////////////////////////////////////////////////
  // bundles between blocks
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic     en;
    logic     we;
    reg_idx_t idx;
    tword_t   wdata;
  } conf_req_t;

  typedef struct packed {
    logic  req;
    logic  we;
    word_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic        cs;
    logic [15:0] addr;
    word_t       rdata;
  } snoop_t;

  // low 32 bits follow the control word layout
  typedef struct packed {
    word_t       length;
    word_t       src_stride;
    word_t       dst_stride;
    logic [28:0] rsvd;
    logic        swap32;
    logic        swap16;
    logic        start;
  } dma_cfg_t;

endpackage

`default_nettype wire

/* dma_conf_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_conf_regs (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire dma_pkg::conf_req_t conf_i,
  output dma_pkg::tword_t        conf_rdata_o,
  input  wire logic              busy_i,
  input  wire logic              done_i,
  input  wire logic              abort_i,
  output dma_pkg::cap_t          src_cap_o,
  output dma_pkg::cap_t          dst_cap_o,
  output dma_pkg::dma_cfg_t      cfg_o,
  output logic                   clear_o
);

  // capability halves and transfer settings
  dma_pkg::cap_t   src_cap_q;
  dma_pkg::cap_t   dst_cap_q;
  dma_pkg::word_t  len_q;
  dma_pkg::word_t  sstride_q;
  dma_pkg::word_t  tstride_q;
  dma_pkg::word_t  ctrl_q;
  dma_pkg::tword_t rdata_q;

  logic            wr;
  logic            wr_idle;
  dma_pkg::word_t  status_w;
  dma_pkg::tword_t rd_word;

  ////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////

  assign wr      = conf_i.en && conf_i.we;
  // settings are frozen while a copy runs
  assign wr_idle = wr && !busy_i;

  // restart write or revocation wipes the whole design next edge
  assign clear_o = (wr && (conf_i.idx == dma_pkg::REG_CTRL) &&
                    conf_i.wdata.data[dma_pkg::CTRL_RESTART]) || abort_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_o) begin
      src_cap_q <= '0;
      dst_cap_q <= '0;
      len_q     <= '0;
      sstride_q <= '0;
      tstride_q <= '0;
      ctrl_q    <= '0;
    end else begin
      if (wr_idle) begin
        case (conf_i.idx)
          dma_pkg::REG_SRC_LO:  src_cap_q.lo <= conf_i.wdata;
          dma_pkg::REG_SRC_HI:  src_cap_q.hi <= dma_pkg::cap_hi_t'(conf_i.wdata);
          dma_pkg::REG_DST_LO:  dst_cap_q.lo <= conf_i.wdata;
          dma_pkg::REG_DST_HI:  dst_cap_q.hi <= dma_pkg::cap_hi_t'(conf_i.wdata);
          dma_pkg::REG_LEN:     len_q        <= conf_i.wdata.data;
          dma_pkg::REG_SSTRIDE: sstride_q    <= conf_i.wdata.data;
          dma_pkg::REG_TSTRIDE: tstride_q    <= conf_i.wdata.data;
          default: ;
        endcase
      end
      // control stays writable while busy
      if (wr && (conf_i.idx == dma_pkg::REG_CTRL)) begin
        ctrl_q <= conf_i.wdata.data;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read-back
  ////////////////////////////////////////////////////////////

  always_comb begin
    status_w                     = '0;
    status_w[dma_pkg::STAT_BUSY] = busy_i;
    status_w[dma_pkg::STAT_DONE] = done_i;
  end

  always_comb begin
    rd_word = '0;
    case (conf_i.idx)
      dma_pkg::REG_SRC_LO:  rd_word = src_cap_q.lo;
      dma_pkg::REG_SRC_HI:  rd_word = dma_pkg::tword_t'(src_cap_q.hi);
      dma_pkg::REG_DST_LO:  rd_word = dst_cap_q.lo;
      dma_pkg::REG_DST_HI:  rd_word = dma_pkg::tword_t'(dst_cap_q.hi);
      dma_pkg::REG_LEN:     rd_word.data = len_q;
      dma_pkg::REG_SSTRIDE: rd_word.data = sstride_q;
      dma_pkg::REG_TSTRIDE: rd_word.data = tstride_q;
      dma_pkg::REG_CTRL:    rd_word.data = ctrl_q;
      dma_pkg::REG_STATUS:  rd_word.data = status_w;
      default: ;
    endcase
  end

  // read data shows up one cycle later and holds until the next read
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_o) begin
      rdata_q <= '0;
    end else if (conf_i.en && !conf_i.we) begin
      rdata_q <= rd_word;
    end
  end

  assign conf_rdata_o = rdata_q;

  ////////////////////////////////////////////////////////////
  // outputs to the checkers and the engine
  ////////////////////////////////////////////////////////////

  assign src_cap_o = src_cap_q;
  assign dst_cap_o = dst_cap_q;

  always_comb begin
    cfg_o            = '0;
    cfg_o.length     = len_q;
    cfg_o.src_stride = sstride_q;
    cfg_o.dst_stride = tstride_q;
    cfg_o.start      = ctrl_q[dma_pkg::CTRL_START];
    cfg_o.swap16     = ctrl_q[dma_pkg::CTRL_SWAP16];
    cfg_o.swap32     = ctrl_q[dma_pkg::CTRL_SWAP32];
  end

  // engine works on the checked capabilities, they must not move under it
  a_caps_frozen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_i && !clear_o |=> $stable(src_cap_q) && $stable(dst_cap_q));

endmodule

`default_nettype wire

/* dma_cap_check.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_cap_check #(
  parameter bit IsTarget = 1'b0
) (
  input  wire dma_pkg::cap_t  cap_i,
  input  wire dma_pkg::word_t length_i,
  output logic                ok_o
);

  // field decode
  logic [3:0]  perms;
  logic [3:0]  exp;
  logic [8:0]  top;
  logic [4:0]  align_sh;

  // 33-bit arithmetic so the bound may sit at 4 GiB
  logic [32:0] addr_ext;
  logic [32:0] align_mask;
  logic [32:0] top_bound;
  logic [32:0] xfer_end;

  logic        tag_ok;
  logic        global_ok;
  logic        access_ok;
  logic        unsealed;
  logic        bounded;

  assign perms = cap_i.hi.perms;
  assign exp   = cap_i.hi.exp;
  assign top   = cap_i.hi.top;

  ////////////////////////////////////////////////////////////
  // top bound
  ////////////////////////////////////////////////////////////

  // the bits below exp+9 come from the top field
  assign align_sh   = {1'b0, exp} + 5'd9;
  assign align_mask = {33{1'b1}} << align_sh;
  assign addr_ext   = {1'b0, cap_i.lo.data};

  assign top_bound = (addr_ext & align_mask) + ({24'b0, top} << exp);
  assign xfer_end  = addr_ext + {1'b0, length_i};

  ////////////////////////////////////////////////////////////
  // validity
  ////////////////////////////////////////////////////////////

  // only the low half tag counts
  assign tag_ok    = cap_i.lo.tag;
  assign global_ok = perms[dma_pkg::PERM_GL];
  // source needs load, target needs store
  assign access_ok = IsTarget ? perms[dma_pkg::PERM_SD] : perms[dma_pkg::PERM_LD];
  assign unsealed  = !perms[dma_pkg::PERM_SE];
  assign bounded   = top_bound >= xfer_end;

  assign ok_o = tag_ok && global_ok && access_ok && unsealed && bounded;

endmodule

`default_nettype wire

/* dma_revoke_snoop.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_revoke_snoop #(
  parameter dma_pkg::word_t HeapBase = 32'h2000_0000,
  parameter int unsigned    MapWords = 2048
) (
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  input  wire dma_pkg::snoop_t snoop_i,
  input  wire dma_pkg::word_t  src_addr_i,
  input  wire dma_pkg::word_t  dst_addr_i,
  input  wire logic            active_i,
  output logic                 abort_o
);

  // granule index relative to the heap start
  dma_pkg::word_t src_gran;
  dma_pkg::word_t dst_gran;
  // map word index, low MAP_BIT_W bits dropped
  dma_pkg::word_t src_widx;
  dma_pkg::word_t dst_widx;

  logic src_hit;
  logic dst_hit;
  logic abort_q;

  assign src_gran = (src_addr_i - HeapBase) >> dma_pkg::GRANULE_SHIFT;
  assign dst_gran = (dst_addr_i - HeapBase) >> dma_pkg::GRANULE_SHIFT;
  assign src_widx = src_gran >> dma_pkg::MAP_BIT_W;
  assign dst_widx = dst_gran >> dma_pkg::MAP_BIT_W;

  // granules outside the map (also below the heap, they wrap high) never match
  assign src_hit = (src_widx < MapWords) && (snoop_i.addr == src_widx[15:0]) &&
                   snoop_i.rdata[src_gran[dma_pkg::MAP_BIT_W-1:0]];
  assign dst_hit = (dst_widx < MapWords) && (snoop_i.addr == dst_widx[15:0]) &&
                   snoop_i.rdata[dst_gran[dma_pkg::MAP_BIT_W-1:0]];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      abort_q <= 1'b0;
    end else begin
      abort_q <= snoop_i.cs && active_i && (src_hit || dst_hit);
    end
  end

  assign abort_o = abort_q;

  // an idle engine is never aborted
  a_abort_active: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    abort_o |-> $past(active_i));

endmodule

`default_nettype wire

/* dma_copy_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_copy_engine (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              clear_i,
  input  wire dma_pkg::dma_cfg_t cfg_i,
  input  wire dma_pkg::cap_t     src_cap_i,
  input  wire dma_pkg::cap_t     dst_cap_i,
  input  wire logic              src_ok_i,
  input  wire logic              dst_ok_i,
  output dma_pkg::mem_req_t      mem_o,
  input  wire logic              mem_gnt_i,
  input  wire logic              mem_rvalid_i,
  input  wire dma_pkg::word_t    mem_rdata_i,
  output logic                   busy_o,
  output logic                   done_o,
  output logic                   irq_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_REQ,
    S_WAIT,
    S_SEND,
    S_AGEN,
    S_DONE
  } state_e;

  state_e         state_q;
  state_e         state_d;
  dma_pkg::word_t byte_cnt_q;
  dma_pkg::word_t byte_cnt_d;
  dma_pkg::word_t src_off_q;
  dma_pkg::word_t dst_off_q;
  dma_pkg::word_t buf_q;
  dma_pkg::word_t swapped;
  logic           irq_q;
  logic           irq_d;
  logic           start_ok;
  logic           req_raw;

  // both capabilities checked and the start bit set
  assign start_ok = cfg_i.start && src_ok_i && dst_ok_i;

  ////////////////////////////////////////////////////////////
  // copy FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    byte_cnt_d = byte_cnt_q;
    irq_d      = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (start_ok) begin
          // empty transfer completes at once
          if (cfg_i.length == '0) begin
            state_d = S_DONE;
            irq_d   = 1'b1;
          end else begin
            state_d = S_REQ;
          end
        end
      end
      // read request held until granted
      S_REQ: begin
        if (mem_gnt_i) begin
          state_d = S_WAIT;
        end
      end
      S_WAIT: begin
        if (mem_rvalid_i) begin
          state_d = S_SEND;
        end
      end
      S_SEND: begin
        if (mem_gnt_i) begin
          byte_cnt_d = byte_cnt_q + 32'd4;
          state_d    = S_AGEN;
        end
      end
      // offsets get a cycle of their own, keeps the multiply off the bus path
      S_AGEN: begin
        if (byte_cnt_q >= cfg_i.length) begin
          state_d = S_DONE;
          irq_d   = 1'b1;
        end else begin
          state_d = S_REQ;
        end
      end
      // left only through restart
      S_DONE: ;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      state_q    <= S_IDLE;
      byte_cnt_q <= '0;
      src_off_q  <= '0;
      dst_off_q  <= '0;
      irq_q      <= 1'b0;
    end else begin
      state_q    <= state_d;
      byte_cnt_q <= byte_cnt_d;
      irq_q      <= irq_d;
      if (state_q == S_AGEN) begin
        src_off_q <= byte_cnt_q * (cfg_i.src_stride + 32'd1);
        dst_off_q <= byte_cnt_q * (cfg_i.dst_stride + 32'd1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // data buffer and byte swap
  ////////////////////////////////////////////////////////////

  // one word in flight between read and write
  always_ff @(posedge clk_i) begin
    if ((state_q == S_WAIT) && mem_rvalid_i) begin
      buf_q <= mem_rdata_i;
    end
  end

  // swap16 wins over swap32
  always_comb begin
    if (cfg_i.swap16) begin
      swapped = {16'b0, buf_q[7:0], buf_q[15:8]};
    end else if (cfg_i.swap32) begin
      swapped = {buf_q[7:0], buf_q[15:8], buf_q[23:16], buf_q[31:24]};
    end else begin
      swapped = buf_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // memory port
  ////////////////////////////////////////////////////////////

  assign req_raw = (state_q == S_REQ) || (state_q == S_SEND);

  always_comb begin
    mem_o     = '0;
    // a pending clear drops the request right away
    mem_o.req = req_raw && !clear_i;
    mem_o.we  = mem_o.req && (state_q == S_SEND);
    if (mem_o.req) begin
      mem_o.addr = mem_o.we ? (dst_cap_i.lo.data + dst_off_q)
                            : (src_cap_i.lo.data + src_off_q);
    end
    if (mem_o.we) begin
      mem_o.wdata = swapped;
    end
  end

  assign busy_o = (state_q != S_IDLE) && (state_q != S_DONE);
  assign done_o = state_q == S_DONE;
  assign irq_o  = irq_q;

  // back-pressure keeps the request where it was
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    mem_o.req && !mem_gnt_i |=> mem_o.req && $stable(mem_o.we) && $stable(mem_o.addr));

  a_irq_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_o |=> !irq_o);

endmodule

`default_nettype wire

/* dma_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_top #(
  parameter dma_pkg::word_t HeapBase = 32'h2000_0000,
  parameter int unsigned    MapWords = 2048
) (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire dma_pkg::conf_req_t conf_i,
  output dma_pkg::tword_t         conf_rdata_o,
  input  wire dma_pkg::snoop_t    snoop_i,
  output dma_pkg::mem_req_t       mem_o,
  input  wire logic               mem_gnt_i,
  input  wire logic               mem_rvalid_i,
  input  wire dma_pkg::word_t     mem_rdata_i,
  output logic                    irq_o
);

  dma_pkg::cap_t     src_cap;
  dma_pkg::cap_t     dst_cap;
  dma_pkg::dma_cfg_t cfg;
  logic              src_ok;
  logic              dst_ok;
  logic              busy;
  logic              done;
  logic              abort;
  logic              clear;

  dma_conf_regs u_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .conf_i       (conf_i),
    .conf_rdata_o (conf_rdata_o),
    .busy_i       (busy),
    .done_i       (done),
    .abort_i      (abort),
    .src_cap_o    (src_cap),
    .dst_cap_o    (dst_cap),
    .cfg_o        (cfg),
    .clear_o      (clear)
  );

  // source needs load permission
  dma_cap_check #(.IsTarget(1'b0)) u_src_check (
    .cap_i    (src_cap),
    .length_i (cfg.length),
    .ok_o     (src_ok)
  );

  // target needs store permission
  dma_cap_check #(.IsTarget(1'b1)) u_dst_check (
    .cap_i    (dst_cap),
    .length_i (cfg.length),
    .ok_o     (dst_ok)
  );

  dma_revoke_snoop #(.HeapBase(HeapBase), .MapWords(MapWords)) u_snoop (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .snoop_i    (snoop_i),
    .src_addr_i (src_cap.lo.data),
    .dst_addr_i (dst_cap.lo.data),
    .active_i   (busy),
    .abort_o    (abort)
  );

  dma_copy_engine u_engine (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .clear_i      (clear),
    .cfg_i        (cfg),
    .src_cap_i    (src_cap),
    .dst_cap_i    (dst_cap),
    .src_ok_i     (src_ok),
    .dst_ok_i     (dst_ok),
    .mem_o        (mem_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .busy_o       (busy),
    .done_o       (done),
    .irq_o        (irq_o)
  );

endmodule

`default_nettype wire

/* tb_dma_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dma_mem (
  input  wire logic              clk_i,
  input  wire dma_pkg::mem_req_t mem_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output dma_pkg::word_t         rdata_o
);

  // sparse storage, only written words live here
  dma_pkg::word_t store [dma_pkg::word_t];

  // background content, every address bit takes part
  function automatic dma_pkg::word_t fill(input dma_pkg::word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a3c_96e1;
  endfunction

  function automatic dma_pkg::word_t peek(input dma_pkg::word_t addr);
    if (store.exists(addr)) begin
      return store[addr];
    end
    return fill(addr);
  endfunction

  ////////////////////////////////////////////////////////////
  // req/gnt/rvalid responder
  ////////////////////////////////////////////////////////////

  initial begin
    dma_pkg::mem_req_t m;
    dma_pkg::word_t    rd_addr;
    logic              gnt_s;
    logic              rd_pend;
    int                gnt_wait;
    int                rd_wait;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    gnt_wait = 0;
    rd_wait  = 0;
    rd_pend  = 1'b0;
    rd_addr  = '0;
    forever begin
      // sample the bus as it was during the cycle that just ended
      @(posedge clk_i);
      m     = mem_i;
      gnt_s = gnt_o;
      #1;
      rvalid_o = 1'b0;
      rdata_o  = '0;
      // read data trails the grant by a random number of cycles
      if (rd_pend) begin
        if (rd_wait == 0) begin
          rvalid_o = 1'b1;
          rdata_o  = peek(rd_addr);
          rd_pend  = 1'b0;
        end else begin
          rd_wait--;
        end
      end
      if (m.req && gnt_s) begin
        if (m.we) begin
          store[m.addr] = m.wdata;
        end else begin
          rd_pend = 1'b1;
          rd_addr = m.addr;
          rd_wait = $urandom % 3;
        end
        gnt_wait = $urandom % 4;
      end else if (m.req && (gnt_wait > 0)) begin
        gnt_wait--;
      end
      gnt_o = (gnt_wait == 0);
    end
  end

endmodule

`default_nettype wire

/* tb_dma.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dma;

  localparam dma_pkg::word_t HeapBase = 32'h2000_0000;
  localparam int NumXfers    = 8;
  localparam int MaxWords    = 16;
  // worst case cycles for one word through grant, rvalid, latch, write grant and address cycle
  localparam int WordCycles  = 20;
  localparam int WatchCycles = (NumXfers + 2) * MaxWords * WordCycles + 1500;

  logic               clk;
  logic               rst_n;
  dma_pkg::conf_req_t conf;
  dma_pkg::tword_t    conf_rdata;
  dma_pkg::snoop_t    snoop;
  dma_pkg::mem_req_t  mem;
  logic               gnt;
  logic               rvalid;
  dma_pkg::word_t     mem_rdata;
  logic               irq;
  int                 errors;
  int                 checks;
  int                 irq_count;

  dma_top #(.HeapBase(HeapBase), .MapWords(2048)) uut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .conf_i       (conf),
    .conf_rdata_o (conf_rdata),
    .snoop_i      (snoop),
    .mem_o        (mem),
    .mem_gnt_i    (gnt),
    .mem_rvalid_i (rvalid),
    .mem_rdata_i  (mem_rdata),
    .irq_o        (irq)
  );

  tb_dma_mem u_mem (
    .clk_i    (clk),
    .mem_i    (mem),
    .gnt_o    (gnt),
    .rvalid_o (rvalid),
    .rdata_o  (mem_rdata)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    if (rst_n && irq) begin
      irq_count++;
    end
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input dma_pkg::word_t exp,
                            input dma_pkg::word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_tword(input string name, input dma_pkg::tword_t exp,
                             input dma_pkg::tword_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus helpers
  ////////////////////////////////////////////////////////////

  // every task starts and ends 1 ns after a rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic conf_write(input dma_pkg::reg_idx_t idx, input dma_pkg::tword_t w);
    conf       = '0;
    conf.en    = 1'b1;
    conf.we    = 1'b1;
    conf.idx   = idx;
    conf.wdata = w;
    tick();
    conf = '0;
  endtask

  task automatic conf_read(input dma_pkg::reg_idx_t idx, output dma_pkg::tword_t r);
    conf     = '0;
    conf.en  = 1'b1;
    conf.idx = idx;
    tick();
    conf = '0;
    r    = conf_rdata;
  endtask

  function automatic dma_pkg::tword_t plain(input dma_pkg::word_t w);
    dma_pkg::tword_t t;
    t.tag  = 1'b0;
    t.data = w;
    return t;
  endfunction

  function automatic dma_pkg::tword_t with_tag(input dma_pkg::word_t w, input logic tag);
    dma_pkg::tword_t t;
    t.tag  = tag;
    t.data = w;
    return t;
  endfunction

  // upper half fields rsvd, perms, spare, exp, base and top
  function automatic dma_pkg::tword_t cap_hi(input logic [3:0] perms, input logic [8:0] top);
    return with_tag({4'b0, perms, 2'b0, 4'd4, 9'b0, top}, 1'b1);
  endfunction

  // reference byte swap where swap16 has priority
  function automatic dma_pkg::word_t swap_model(input dma_pkg::word_t w, input logic s16,
                                                input logic s32);
    if (s16) begin
      return {16'b0, w[7:0], w[15:8]};
    end
    if (s32) begin
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
    end
    return w;
  endfunction

  task automatic restart();
    conf_write(dma_pkg::REG_CTRL, plain(32'h1 << dma_pkg::CTRL_RESTART));
  endtask

  task automatic setup_caps(input dma_pkg::word_t src, input dma_pkg::word_t dst,
                            input logic src_tag, input dma_pkg::tword_t src_hi,
                            input dma_pkg::tword_t dst_hi, input dma_pkg::word_t len);
    conf_write(dma_pkg::REG_SRC_LO, with_tag(src, src_tag));
    conf_write(dma_pkg::REG_SRC_HI, src_hi);
    conf_write(dma_pkg::REG_DST_LO, with_tag(dst, 1'b1));
    conf_write(dma_pkg::REG_DST_HI, dst_hi);
    conf_write(dma_pkg::REG_LEN, plain(len));
  endtask

  task automatic wait_req(output logic seen);
    seen = 1'b0;
    for (int c = 0; c < 100 && !seen; c++) begin
      @(posedge clk);
      seen = mem.req;
      #1;
    end
    if (!seen) begin
      errors++;
      $display("no memory request seen after start");
    end
  endtask

  task automatic wait_irq(output logic seen);
    seen = 1'b0;
    for (int c = 0; c < MaxWords * WordCycles && !seen; c++) begin
      @(posedge clk);
      seen = irq;
      #1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic readback_test();
    dma_pkg::tword_t rd;
    conf_write(dma_pkg::REG_LEN, plain(32'h40));
    conf_write(dma_pkg::REG_SSTRIDE, plain(32'h3));
    conf_write(dma_pkg::REG_TSTRIDE, plain(32'h1));
    conf_write(dma_pkg::REG_CTRL, plain(32'h6));
    conf_read(dma_pkg::REG_LEN, rd);
    check_tword("readback len", plain(32'h40), rd);
    conf_read(dma_pkg::REG_SSTRIDE, rd);
    check_tword("readback sstride", plain(32'h3), rd);
    conf_read(dma_pkg::REG_TSTRIDE, rd);
    check_tword("readback tstride", plain(32'h1), rd);
    conf_read(dma_pkg::REG_CTRL, rd);
    check_tword("readback ctrl", plain(32'h6), rd);
  endtask

  task automatic xfer_test(input int n);
    dma_pkg::word_t  src;
    dma_pkg::word_t  dst;
    dma_pkg::word_t  len;
    dma_pkg::word_t  ss;
    dma_pkg::word_t  ts;
    dma_pkg::word_t  ctrl;
    dma_pkg::tword_t rd;
    logic            s16;
    logic            s32;
    logic            seen;
    int              words;
    int              irq_before;
    words = 1 + ($urandom % MaxWords);
    len   = words * 4;
    ss    = $urandom % 4;
    ts    = $urandom % 4;
    s16   = $urandom % 2;
    s32   = $urandom % 2;
    src   = HeapBase + n * 32'h4000 + 32'h100 + ($urandom % 64) * 4;
    dst   = HeapBase + 32'h10_0000 + n * 32'h4000 + 32'h100 + ($urandom % 64) * 4;
    restart();
    conf_read(dma_pkg::REG_STATUS, rd);
    check_tword("status after restart", plain(32'h0), rd);
    setup_caps(src, dst, 1'b1, cap_hi(4'b0011, 9'd511), cap_hi(4'b0101, 9'd511), len);
    conf_write(dma_pkg::REG_SSTRIDE, plain(ss));
    conf_write(dma_pkg::REG_TSTRIDE, plain(ts));
    ctrl = '0;
    ctrl[dma_pkg::CTRL_START]  = 1'b1;
    ctrl[dma_pkg::CTRL_SWAP16] = s16;
    ctrl[dma_pkg::CTRL_SWAP32] = s32;
    irq_before = irq_count;
    conf_write(dma_pkg::REG_CTRL, plain(ctrl));
    if (n == 0) begin
      // capability write while busy must be dropped
      wait_req(seen);
      conf_write(dma_pkg::REG_SRC_LO, with_tag(32'hdead_bee0, 1'b1));
    end
    wait_irq(seen);
    if (!seen) begin
      errors++;
      $display("transfer %0d never raised its interrupt", n);
    end
    tick();
    tick();
    check_word($sformatf("xfer %0d irq pulses", n), 32'd1, irq_count - irq_before);
    conf_read(dma_pkg::REG_STATUS, rd);
    check_tword($sformatf("xfer %0d status", n), plain(32'h1 << dma_pkg::STAT_DONE), rd);
    if (n == 0) begin
      conf_read(dma_pkg::REG_SRC_LO, rd);
      check_tword("src cap frozen while busy", with_tag(src, 1'b1), rd);
    end
    // word k sits at byte offset 4k times stride plus one
    for (int k = 0; k < words; k++) begin
      check_word($sformatf("xfer %0d word %0d", n, k),
                 swap_model(u_mem.fill(src + 4 * k * (ss + 1)), s16, s32),
                 u_mem.peek(dst + 4 * k * (ts + 1)));
    end
  endtask

  task automatic reject_test(input int f);
    dma_pkg::word_t  src;
    dma_pkg::word_t  dst;
    dma_pkg::tword_t src_hi;
    dma_pkg::tword_t dst_hi;
    logic            src_tag;
    logic            seen;
    int              irq_before;
    src     = HeapBase + 32'h6_0100;
    dst     = HeapBase + 32'h16_0100;
    src_tag = 1'b1;
    src_hi  = cap_hi(4'b0011, 9'd511);
    dst_hi  = cap_hi(4'b0101, 9'd511);
    // one fault per run
    case (f)
      0: src_tag = 1'b0;
      1: src_hi  = cap_hi(4'b0010, 9'd511);
      2: dst_hi  = cap_hi(4'b0001, 9'd511);
      3: dst_hi  = cap_hi(4'b1101, 9'd511);
      default: src_hi = cap_hi(4'b0011, 9'd0);
    endcase
    restart();
    setup_caps(src, dst, src_tag, src_hi, dst_hi, 32'd32);
    irq_before = irq_count;
    conf_write(dma_pkg::REG_CTRL, plain(32'h1));
    seen = 1'b0;
    repeat (50) begin
      @(posedge clk);
      if (mem.req) begin
        seen = 1'b1;
      end
      #1;
    end
    check_flag($sformatf("reject %0d req", f), 1'b0, seen);
    check_word($sformatf("reject %0d irq", f), 32'd0, irq_count - irq_before);
  endtask

  task automatic revoke_test();
    dma_pkg::word_t  src;
    dma_pkg::word_t  gran;
    dma_pkg::tword_t rd;
    logic            seen;
    int              irq_before;
    src  = HeapBase + 32'h4_0100;
    gran = (src - HeapBase) >> dma_pkg::GRANULE_SHIFT;
    restart();
    setup_caps(src, HeapBase + 32'h14_0100, 1'b1, cap_hi(4'b0011, 9'd511),
               cap_hi(4'b0101, 9'd511), 32'd64);
    irq_before = irq_count;
    conf_write(dma_pkg::REG_CTRL, plain(32'h1));
    wait_req(seen);
    // neighbouring map word with all bits revoked
    snoop       = '0;
    snoop.cs    = 1'b1;
    snoop.addr  = 16'(gran >> dma_pkg::MAP_BIT_W) + 16'd1;
    snoop.rdata = '1;
    tick();
    snoop = '0;
    tick();
    conf_read(dma_pkg::REG_STATUS, rd);
    check_tword("busy after foreign snoop", plain(32'h1 << dma_pkg::STAT_BUSY), rd);
    // now hit the source granule
    snoop.cs    = 1'b1;
    snoop.addr  = 16'(gran >> dma_pkg::MAP_BIT_W);
    snoop.rdata = 32'h1 << gran[dma_pkg::MAP_BIT_W-1:0];
    tick();
    snoop = '0;
    check_flag("req dropped on revoke", 1'b0, mem.req);
    tick();
    conf_read(dma_pkg::REG_LEN, rd);
    check_tword("len cleared", plain(32'h0), rd);
    conf_read(dma_pkg::REG_SRC_LO, rd);
    check_tword("src cleared", plain(32'h0), rd);
    conf_read(dma_pkg::REG_CTRL, rd);
    check_tword("ctrl cleared", plain(32'h0), rd);
    conf_read(dma_pkg::REG_STATUS, rd);
    check_tword("status cleared", plain(32'h0), rd);
    repeat (20) tick();
    check_word("revoke irq", 32'd0, irq_count - irq_before);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h546c));
    clk       = 1'b0;
    rst_n     = 1'b0;
    conf      = '0;
    snoop     = '0;
    errors    = 0;
    checks    = 0;
    irq_count = 0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    tick();
    readback_test();
    for (int n = 0; n < NumXfers; n++) begin
      xfer_test(n);
    end
    for (int f = 0; f < 5; f++) begin
      reject_test(f);
    end
    revoke_test();
    // a fresh transfer after the abort
    xfer_test(NumXfers - 1);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WatchCycles * 10);
    $display("timeout, the run did not finish in %0d cycles", WatchCycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
dma_pkg.sv
dma_conf_regs.sv
dma_cap_check.sv
dma_revoke_snoop.sv
dma_copy_engine.sv
dma_top.sv
tb_dma_mem.sv
tb_dma.sv

/* Bender.yml */
package:
  name: dma_cap_copy

sources:
  - dma_pkg.sv
  - dma_conf_regs.sv
  - dma_cap_check.sv
  - dma_revoke_snoop.sv
  - dma_copy_engine.sv
  - dma_top.sv
  - target: test
    files:
      - tb_dma_mem.sv
      - tb_dma.sv
